// ==== bench/gearbox_tb.sv ====
// Gearbox testbench with a bit-stream model per lane and directed tests
`timescale 1ns/10ps

module gearbox_tb;

    import gearbox_pkg::*;

    localparam logic [num_lanes-1:0] all_lanes = '1;
    localparam int stall_lane = 5;

    // Reset twice, idle checks, two full streams, gapped stream, stall, clear
    localparam int test_cycles = 2 * 8 + 6 + 2 * (42 + 2) + 21 * (1 + 3) + 2 + 10 + 3;
    localparam int max_cycles  = 14 * test_cycles;

    logic                 clk = 1'b0;
    logic                 rstb;
    gb_beat_t             in_beat;
    logic                 clear_err;
    logic [out_w-1:0]     words [num_lanes];
    logic                 group_valid;
    gb_status_t           status;

    // Model state
    logic [63:0]          model_buf [num_lanes];    // Oldest bit at bit 0
    int                   model_cnt [num_lanes];
    logic [out_w-1:0]     exp_word [num_lanes];
    logic [num_lanes-1:0] exp_emit;
    logic [num_lanes-1:0] prev_emit;
    logic [cnt_w-1:0]     exp_count;
    logic                 exp_oos;
    logic                 exp_err;

    logic [15:0]          lfsr;
    int                   groups_seen;
    int                   cycles;
    int                   errors;
    int                   stream_groups;

    gearbox_top dut (
        .clk         (clk),
        .rstb        (rstb),
        .in_beat     (in_beat),
        .clear_err   (clear_err),
        .words       (words),
        .group_valid (group_valid),
        .status      (status)
    );

    always #2 clk = ~clk;

    // Stuck run guard
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout at %0t, cycle limit reached before the tests finished", $time);
            fail_run();
        end
    end

    task automatic fail_run();
        errors = errors + 1;
        $display("ERRORS FOUND");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error %0t %s got %0h expected %0h", $time, name, got, exp);
            fail_run();
        end
    endtask

    // Taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic draw_bits(input int n, output logic [in_w-1:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            bits[k] = lfsr[15];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < num_lanes; i++) begin
            model_buf[i] = '0;
            model_cnt[i] = 0;
            exp_word[i]  = '0;
        end
        exp_emit  = '0;
        prev_emit = '0;
        exp_count = '0;
        exp_oos   = 1'b0;
        exp_err   = 1'b0;
    endtask

    task automatic apply_reset();
        rstb      = 1'b0;
        in_beat   = '0;
        clear_err = 1'b0;
        clear_model();
        repeat (8) @(negedge clk);
        rstb = 1'b1;
    endtask

    // Drive at the falling edge and check at the next one
    task automatic run_cycle(input logic [num_lanes-1:0] mask, input logic clear);
        logic [in_w-1:0]           beat;
        logic [num_lanes*in_w-1:0] data;
        logic                      prev_all;
        logic                      prev_oos;

        // Status follows the emit pattern of the previous cycle
        prev_all = &prev_emit;
        prev_oos = (|prev_emit) && !prev_all;
        if (prev_all) begin
            exp_count = exp_count + cnt_w'(1);
        end
        exp_oos = prev_oos;
        if (prev_oos) begin
            exp_err = 1'b1;
        end else if (clear) begin
            exp_err = 1'b0;
        end

        data     = '0;
        exp_emit = '0;
        for (int i = 0; i < num_lanes; i++) begin
            if (mask[i]) begin
                draw_bits(in_w, beat);
                data[i*in_w +: in_w] = beat;
                model_buf[i] = model_buf[i] | (64'(beat) << model_cnt[i]);
                model_cnt[i] = model_cnt[i] + in_w;
                if (model_cnt[i] >= out_w) begin     // Pop the oldest bits
                    exp_word[i]  = model_buf[i][out_w-1:0];
                    model_buf[i] = model_buf[i] >> out_w;
                    model_cnt[i] = model_cnt[i] - out_w;
                    exp_emit[i]  = 1'b1;
                end
            end
        end

        in_beat.lane_valid = mask;
        in_beat.data       = data;
        clear_err          = clear;
        @(posedge clk);
        @(negedge clk);

        check_val("group_valid", 32'(group_valid), 32'(&exp_emit));
        for (int i = 0; i < num_lanes; i++) begin
            if (exp_emit[i]) begin
                check_val($sformatf("words[%0d]", i), 32'(words[i]), 32'(exp_word[i]));
            end
        end
        check_val("status.out_of_sync", 32'(status.out_of_sync), 32'(exp_oos));
        check_val("status.sync_err", 32'(status.sync_err), 32'(exp_err));
        check_val("status.group_count", status.group_count, exp_count);

        if (group_valid) begin
            groups_seen = groups_seen + 1;
        end
        prev_emit = exp_emit;

        in_beat.lane_valid = '0;
        clear_err          = 1'b0;
    endtask

    task automatic check_reset_state();
        check_val("group_valid", 32'(group_valid), 32'd0);
        check_val("status.out_of_sync", 32'(status.out_of_sync), 32'd0);
        check_val("status.sync_err", 32'(status.sync_err), 32'd0);
        check_val("status.group_count", status.group_count, 32'd0);
        repeat (6) run_cycle('0, 1'b0);      // Nothing moves without beats
        check_val("status.group_count", status.group_count, 32'd0);
    endtask

    // 42 beats of 16 bits make 32 words of 21 bits
    task automatic stream_back_to_back(output int groups);
        int               start;
        logic [cnt_w-1:0] cnt0;
        start = groups_seen;
        cnt0  = exp_count;
        repeat (42) run_cycle(all_lanes, 1'b0);
        repeat (2) run_cycle('0, 1'b0);
        groups = groups_seen - start;
        check_val("groups in back to back stream", 32'(groups), 32'd32);
        check_val("status.group_count", status.group_count, cnt0 + 32'd32);
    endtask

    task automatic stream_with_gaps();
        logic [in_w-1:0]  bits;
        logic [cnt_w-1:0] cnt0;
        int               gap;
        cnt0 = exp_count;
        for (int b = 0; b < 21; b++) begin
            run_cycle(all_lanes, 1'b0);
            draw_bits(2, bits);
            gap = int'(bits[1:0]);
            repeat (gap) run_cycle('0, 1'b0);
        end
        repeat (2) run_cycle('0, 1'b0);
        check_val("status.group_count", status.group_count, cnt0 + 32'd16);
    endtask

    task automatic stall_one_lane();
        logic [num_lanes-1:0] stall_mask;
        logic                 saw_oos;
        stall_mask = all_lanes & ~(num_lanes'(1) << stall_lane);
        saw_oos    = 1'b0;

        run_cycle(all_lanes, 1'b0);          // All fills at 16
        run_cycle(stall_mask, 1'b0);         // Others emit, the stalled lane does not
        check_val("group_valid", 32'(group_valid), 32'd0);
        check_val("status.sync_err", 32'(status.sync_err), 32'd0);

        run_cycle(all_lanes, 1'b0);
        check_val("status.out_of_sync", 32'(status.out_of_sync), 32'd1);
        check_val("status.sync_err", 32'(status.sync_err), 32'd1);

        repeat (5) begin
            run_cycle(all_lanes, 1'b0);
            if (status.out_of_sync) begin
                saw_oos = 1'b1;
            end
        end
        repeat (2) run_cycle('0, 1'b0);
        assert (saw_oos) else begin
            $display("lanes stayed in step after the stall, no later out of sync seen");
            fail_run();
        end
        check_val("status.sync_err", 32'(status.sync_err), 32'd1);  // Still sticky
    endtask

    task automatic clear_and_restart();
        run_cycle('0, 1'b0);
        run_cycle('0, 1'b1);
        check_val("status.sync_err", 32'(status.sync_err), 32'd0);

        @(negedge clk);
        apply_reset();
        run_cycle('0, 1'b0);
        check_val("status.group_count", status.group_count, 32'd0);

        // Model starts from empty lanes, so matching data proves the fills restarted
        stream_back_to_back(stream_groups);
        check_val("status.group_count", status.group_count, 32'(stream_groups));
    endtask

    initial begin
        rstb        = 1'b0;
        in_beat     = '0;
        clear_err   = 1'b0;
        lfsr        = 16'd57;
        groups_seen = 0;
        cycles      = 0;
        errors      = 0;

        apply_reset();
        check_reset_state();
        stream_back_to_back(stream_groups);
        stream_with_gaps();
        stall_one_lane();
        clear_and_restart();

        if (errors == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

// ==== design/gearbox_array.sv ====
// Gearbox lane array with the all-lanes group valid and the out-of-sync flag
`timescale 1ns/10ps

module gearbox_array (
    input  logic                          clk,
    input  logic                          rstb,
    input  gearbox_pkg::gb_beat_t         in_beat,
    output logic [gearbox_pkg::out_w-1:0] words [gearbox_pkg::num_lanes],
    output logic                          group_valid,
    output logic                          out_of_sync
);

    import gearbox_pkg::*;

    logic [num_lanes-1:0] lane_emit;    // Registered word_valid of each lane
    logic                 any_emit;
    logic                 all_emit;

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        gearbox_lane u_lane (
            .clk        (clk),
            .rstb       (rstb),
            .valid_in   (in_beat.lane_valid[i]),
            .data_in    (in_beat.data[i*in_w +: in_w]),
            .word_valid (lane_emit[i]),
            .word       (words[i])
        );
    end

    // Straight off the lane registers, no extra cycle
    always_comb begin
        any_emit = |lane_emit;
        all_emit = &lane_emit;
    end

    assign group_valid = all_emit;
    assign out_of_sync = any_emit && !all_emit;  // Some lanes emit, not all

endmodule

// ==== design/gearbox_lane.sv ====
// Gearbox lane that packs 16-bit beats into 21-bit words, oldest bit first
`timescale 1ns/10ps

module gearbox_lane (
    input  logic                          clk,
    input  logic                          rstb,
    input  logic                          valid_in,
    input  logic [gearbox_pkg::in_w-1:0]  data_in,
    output logic                          word_valid,
    output logic [gearbox_pkg::out_w-1:0] word
);

    import gearbox_pkg::*;

    localparam int buf_w  = out_w - 1;      // Most bits ever left over
    localparam int fill_w = $clog2(out_w);  // Holds 0 to buf_w
    localparam int span_w = buf_w + in_w;   // Leftover bits plus one beat

    localparam logic [fill_w:0] beat_bits = in_w[fill_w:0];
    localparam logic [fill_w:0] word_bits = out_w[fill_w:0];

    logic [buf_w-1:0]  buf_q;       // Leftover bits, oldest at bit 0
    logic [fill_w-1:0] fill_q;      // Valid bits in buf_q
    logic [buf_w-1:0]  buf_mask;
    logic [fill_w:0]   fill_sum;
    logic [fill_w:0]   fill_left;
    logic [span_w-1:0] span;
    logic [span_w-1:0] span_rest;
    logic              emit;

    always_comb begin
        fill_sum  = {1'b0, fill_q} + beat_bits;
        fill_left = fill_sum - word_bits;

        // Bits above the fill are stale, keep them out of the span
        buf_mask = ~({buf_w{1'b1}} << fill_q);

        // New beat lands right above the buffered bits
        span = ({{(span_w-in_w){1'b0}}, data_in} << fill_q)
             | {{in_w{1'b0}}, buf_q & buf_mask};

        span_rest = span >> out_w;  // What is left after a word goes out

        emit = valid_in && (fill_sum >= word_bits);
    end

    // Fill count and word strobe
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            fill_q     <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= emit;
            if (valid_in) begin
                if (emit) begin
                    fill_q <= fill_left[fill_w-1:0];
                end else begin
                    fill_q <= fill_sum[fill_w-1:0];
                end
            end
        end
    end

    // Buffer and output word
    always_ff @(posedge clk) begin
        if (valid_in) begin
            if (emit) begin
                buf_q <= span_rest[buf_w-1:0];
            end else begin
                buf_q <= span[buf_w-1:0];   // Fits, fill stays at most 20
            end
        end
        if (emit) begin
            word <= span[out_w-1:0];        // Oldest 21 bits
        end
    end

endmodule

// ==== design/gearbox_status.sv ====
// Gearbox status block with the group counter and the sticky sync error
`timescale 1ns/10ps

module gearbox_status (
    input  logic                   clk,
    input  logic                   rstb,
    input  logic                   group_valid,
    input  logic                   out_of_sync,
    input  logic                   clear_err,
    output gearbox_pkg::gb_status_t status
);

    import gearbox_pkg::*;

    logic [cnt_w-1:0] group_count_q;
    logic             oos_q;
    logic             sync_err_q;

    // Counts whole word groups, wraps at the top
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            group_count_q <= '0;
        end else if (group_valid) begin
            group_count_q <= group_count_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            oos_q <= 1'b0;
        end else begin
            oos_q <= out_of_sync;
        end
    end

    // A new error wins over a clear on the same edge
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            sync_err_q <= 1'b0;
        end else if (out_of_sync) begin
            sync_err_q <= 1'b1;
        end else if (clear_err) begin
            sync_err_q <= 1'b0;
        end
    end

    always_comb begin
        status.out_of_sync = oos_q;
        status.sync_err    = sync_err_q;
        status.group_count = group_count_q;
    end

endmodule

// ==== design/gearbox_top.sv ====
// Gearbox top level joining the lane array and the status block
`timescale 1ns/10ps

module gearbox_top (
    input  logic                          clk,
    input  logic                          rstb,
    input  gearbox_pkg::gb_beat_t         in_beat,
    input  logic                          clear_err,
    output logic [gearbox_pkg::out_w-1:0] words [gearbox_pkg::num_lanes],
    output logic                          group_valid,
    output gearbox_pkg::gb_status_t       status
);

    logic out_of_sync;  // Array flag into the status block

    // Words and group_valid one cycle after the completing beat
    gearbox_array u_array (
        .clk         (clk),
        .rstb        (rstb),
        .in_beat     (in_beat),
        .words       (words),
        .group_valid (group_valid),
        .out_of_sync (out_of_sync)
    );

    // Status lands one cycle after that
    gearbox_status u_status (
        .clk         (clk),
        .rstb        (rstb),
        .group_valid (group_valid),
        .out_of_sync (out_of_sync),
        .clear_err   (clear_err),
        .status      (status)
    );

endmodule

// ==== gearbox.f ====
gearbox_pkg.sv
design/gearbox_lane.sv
design/gearbox_array.sv
design/gearbox_status.sv
design/gearbox_top.sv
bench/gearbox_tb.sv

// ==== gearbox_pkg.sv ====
// Gearbox package with lane widths, lane count and the shared beat and status structs
package gearbox_pkg;

    parameter int in_w      = 16;   // Beat width per lane
    parameter int out_w     = 21;   // Output word width
    parameter int num_lanes = 28;
    parameter int cnt_w     = 32;   // Group counter width

    // One input beat for the whole array
    // Lane i owns lane_valid[i] and data[i*in_w +: in_w]
    typedef struct packed {
        logic [num_lanes-1:0]      lane_valid;
        logic [num_lanes*in_w-1:0] data;
    } gb_beat_t;

    // Status seen by the outside world
    typedef struct packed {
        logic             out_of_sync;  // Registered copy of the array flag
        logic             sync_err;     // Sticky until clear_err
        logic [cnt_w-1:0] group_count;  // Wraps
    } gb_status_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the gearbox testbench with Verilator, runs it and checks the log

set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir
bin=gearbox_sim

verilator --binary --assert -j 0 \
    --timescale 1ns/10ps \
    --top-module gearbox_tb \
    -Mdir "$obj" -o "$bin" \
    -f gearbox.f
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./$obj/$bin" > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "ERRORS FOUND" "$log"; then
    echo "Simulation reported failures, see $log"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "NO ERRORS" "$log"; then
    echo "Simulation ended without a result line"
    exit 1
fi

echo "Simulation passed"
exit 0
